/* verilog/isa_pkg.sv */
package isa_pkg;

   // Datapath width and register count of the slice
   localparam int XLEN     = 32;
   localparam int NUM_REGS = 32;

   typedef logic [XLEN-1:0] word_t;
   typedef logic [31:0]     instr_t;
   typedef logic [4:0]      reg_addr_t;
   typedef logic [2:0]      funct3_t;

   // Major opcode as seen in bits 6:2
   typedef logic [4:0]      opcode_t;

   // Supported major opcodes
   localparam opcode_t OPC_OP_IMM = 5'b00100;
   localparam opcode_t OPC_OP     = 5'b01100;
   localparam opcode_t OPC_LUI    = 5'b01101;

   // funct3 values common to OP and OP-IMM
   localparam funct3_t F3_ADD  = 3'b000;
   localparam funct3_t F3_SLL  = 3'b001;
   localparam funct3_t F3_SLT  = 3'b010;
   localparam funct3_t F3_SLTU = 3'b011;
   localparam funct3_t F3_XOR  = 3'b100;
   localparam funct3_t F3_SR   = 3'b101;
   localparam funct3_t F3_OR   = 3'b110;
   localparam funct3_t F3_AND  = 3'b111;

endpackage

/* verilog/core_pkg.sv */
package core_pkg;

   // Which serial result the ALU shifts into its result word
   typedef enum logic [1:0] {
      ADD,
      LT,
      BOOL,
      IMM
   } alu_rd_sel_e;

   // Execution phases of one instruction
   typedef enum logic [1:0] {
      IDLE,
      RUN,
      RETIRE
   } seq_state_e;

   // Index of the bit being processed, LSB first
   typedef logic [4:0] bit_cnt_t;

endpackage

/* verilog/alu_ctrl_if.sv */
interface alu_ctrl_if;
   import core_pkg::*;

   logic        sub;
   logic [1:0]  bool_op;
   logic        cmp_uns;
   alu_rd_sel_e rd_sel;
   logic        op_b_imm;
   // Immediate bit for the current bit cycle
   logic        imm_bit;

   modport dec (
      output sub,
      output bool_op,
      output cmp_uns,
      output rd_sel,
      output op_b_imm,
      output imm_bit
   );

   modport alu (
      input sub,
      input bool_op,
      input cmp_uns,
      input rd_sel,
      input op_b_imm,
      input imm_bit
   );

endinterface

/* verilog/serial_decode.sv */
module serial_decode (
   input  logic               clk,
   input  logic               i_rst,
   input  logic               i_instr_valid,
   input  logic               i_accept,
   input  isa_pkg::instr_t    i_instr,
   input  logic               i_cnt_en,
   output isa_pkg::reg_addr_t o_rs1_addr,
   output isa_pkg::reg_addr_t o_rs2_addr,
   output isa_pkg::reg_addr_t o_rd_addr,
   output logic               o_rd_en,
   output logic               o_illegal,
   alu_ctrl_if.dec            ctrl
);
   import isa_pkg::*;
   import core_pkg::*;

   logic    capture;
   opcode_t opcode;
   logic    quad_ok;
   funct3_t funct3;
   logic    op30;
   word_t   imm;
   logic    is_op;
   logic    is_op_imm;
   logic    is_lui;
   logic    is_shift;
   logic    legal;

   assign capture = i_instr_valid & i_accept;

   // Opcode and quadrant bits that decide legality
   always_ff @(posedge clk) begin
      if (i_rst) begin
         opcode  <= '0;
         quad_ok <= 1'b0;
      end else if (capture) begin
         opcode  <= i_instr[6:2];
         quad_ok <= &i_instr[1:0];
      end
   end

   always_ff @(posedge clk) begin
      if (capture) begin
         funct3     <= i_instr[14:12];
         op30       <= i_instr[30];
         o_rd_addr  <= i_instr[11:7];
         o_rs1_addr <= i_instr[19:15];
         o_rs2_addr <= i_instr[24:20];
      end
   end

   // U-type for LUI and I-type otherwise
   // Rotated right once per bit cycle
   always_ff @(posedge clk) begin
      if (capture) begin
         if (i_instr[6:2] == OPC_LUI) begin
            imm <= {i_instr[31:12], 12'b0};
         end else begin
            imm <= {{20{i_instr[31]}}, i_instr[31:20]};
         end
      end else if (i_cnt_en) begin
         imm <= {imm[0], imm[31:1]};
      end
   end

   assign ctrl.imm_bit = imm[0];

   assign is_op     = (opcode == OPC_OP);
   assign is_op_imm = (opcode == OPC_OP_IMM);
   assign is_lui    = (opcode == OPC_LUI);
   assign is_shift  = (funct3 == F3_SLL) || (funct3 == F3_SR);

   // Shifts are not implemented in this slice
   assign legal = quad_ok & (((is_op | is_op_imm) & ~is_shift) | is_lui);

   assign o_illegal = ~legal;
   assign o_rd_en   = legal & (|o_rd_addr);

   assign ctrl.sub      = is_op & op30;
   assign ctrl.bool_op  = funct3[1:0];
   assign ctrl.cmp_uns  = (funct3 == F3_SLTU);
   assign ctrl.op_b_imm = ~is_op;

   always_comb begin
      if (is_lui) begin
         ctrl.rd_sel = IMM;
      end else begin
         case (funct3)
            F3_ADD:  ctrl.rd_sel = ADD;
            F3_SLL:  ctrl.rd_sel = ADD;
            F3_SLT:  ctrl.rd_sel = LT;
            F3_SLTU: ctrl.rd_sel = LT;
            F3_XOR:  ctrl.rd_sel = BOOL;
            F3_SR:   ctrl.rd_sel = ADD;
            F3_OR:   ctrl.rd_sel = BOOL;
            F3_AND:  ctrl.rd_sel = BOOL;
            default: ctrl.rd_sel = ADD;
         endcase
      end
   end

endmodule

/* verilog/serial_alu.sv */
module serial_alu #(
   parameter int XLEN = isa_pkg::XLEN
) (
   input  logic               clk,
   input  logic               i_rst,
   input  logic               i_cnt_en,
   input  logic               i_first,
   input  core_pkg::bit_cnt_t i_bit_cnt,
   input  logic               i_rs1_bit,
   input  logic               i_rs2_bit,
   alu_ctrl_if.alu            ctrl,
   output isa_pkg::word_t     o_result
);
   import core_pkg::*;

   localparam bit_cnt_t LAST_BIT = bit_cnt_t'(XLEN - 1);

   logic op_b;
   logic invert;
   logic b_eff;
   logic carry_q;
   logic carry_in;
   logic sum;
   logic carry_out;
   logic bool_bit;
   logic lt_bit;
   logic res_bit;
   logic last_bit;

   assign op_b = ctrl.op_b_imm ? ctrl.imm_bit : i_rs2_bit;

   // Compare is a subtraction whose sum is thrown away
   assign invert = ctrl.sub | (ctrl.rd_sel == LT);
   assign b_eff  = op_b ^ invert;

   // Carry of one on the first bit completes the two's complement
   assign carry_in  = i_first ? invert : carry_q;
   assign sum       = i_rs1_bit ^ b_eff ^ carry_in;
   assign carry_out = (i_rs1_bit & b_eff) | (carry_in & (i_rs1_bit ^ b_eff));

   always_ff @(posedge clk) begin
      if (i_rst) begin
         carry_q <= 1'b0;
      end else if (i_cnt_en) begin
         carry_q <= carry_out;
      end
   end

   always_comb begin
      case (ctrl.bool_op)
         2'b10:   bool_bit = i_rs1_bit | op_b;
         2'b11:   bool_bit = i_rs1_bit & op_b;
         default: bool_bit = i_rs1_bit ^ op_b;
      endcase
   end

   // Valid on the sign bit only
   // Unsigned less-than is the missing carry out
   // Signed with differing signs takes the sign of a
   assign lt_bit = ctrl.cmp_uns ? ~carry_out :
                   (i_rs1_bit ^ op_b) ? i_rs1_bit : sum;

   always_comb begin
      case (ctrl.rd_sel)
         ADD:     res_bit = sum;
         BOOL:    res_bit = bool_bit;
         IMM:     res_bit = ctrl.imm_bit;
         default: res_bit = 1'b0;
      endcase
   end

   assign last_bit = (i_bit_cnt == LAST_BIT);

   always_ff @(posedge clk) begin
      if (i_cnt_en) begin
         if (last_bit && (ctrl.rd_sel == LT)) begin
            o_result <= {{(XLEN - 1){1'b0}}, lt_bit};
         end else begin
            o_result <= {res_bit, o_result[XLEN-1:1]};
         end
      end
   end

endmodule

/* verilog/serial_regfile.sv */
module serial_regfile #(
   parameter int XLEN = isa_pkg::XLEN
) (
   input  logic               clk,
   input  logic               i_rst,
   input  core_pkg::bit_cnt_t i_bit_cnt,
   input  isa_pkg::reg_addr_t i_rs1_addr,
   input  isa_pkg::reg_addr_t i_rs2_addr,
   input  logic               i_wr_en,
   input  isa_pkg::reg_addr_t i_rd_addr,
   input  isa_pkg::word_t     i_wr_data,
   output logic               o_rs1_bit,
   output logic               o_rs2_bit
);
   import isa_pkg::*;

   logic [XLEN-1:0] regs [NUM_REGS];

   // x0 is never written, so it stays at its reset value of zero
   always_ff @(posedge clk) begin
      if (i_rst) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (i_wr_en && (i_rd_addr != '0)) begin
         regs[i_rd_addr] <= i_wr_data;
      end
   end

   // One bit per source register for the current bit cycle
   assign o_rs1_bit = regs[i_rs1_addr][i_bit_cnt];
   assign o_rs2_bit = regs[i_rs2_addr][i_bit_cnt];

endmodule

/* verilog/exec_sequencer.sv */
module exec_sequencer #(
   parameter int XLEN = isa_pkg::XLEN
) (
   input  logic               clk,
   input  logic               i_rst,
   input  logic               i_instr_valid,
   output logic               o_accept,
   output logic               o_cnt_en,
   output logic               o_first,
   output logic               o_last,
   output core_pkg::bit_cnt_t o_bit_cnt,
   output logic               o_retire,
   output logic               o_ready
);
   import core_pkg::*;

   localparam bit_cnt_t LAST_BIT = bit_cnt_t'(XLEN - 1);

   seq_state_e state;
   bit_cnt_t   bit_cnt;
   logic       last_q;

   always_ff @(posedge clk) begin
      if (i_rst) begin
         state   <= IDLE;
         bit_cnt <= '0;
         last_q  <= 1'b0;
      end else begin
         last_q <= 1'b0;
         case (state)
            IDLE: begin
               if (o_accept) begin
                  state   <= RUN;
                  bit_cnt <= '0;
               end
            end
            RUN: begin
               // One extra cycle after the last bit for the write
               if (last_q) begin
                  state <= RETIRE;
               end else begin
                  bit_cnt <= bit_cnt + bit_cnt_t'(1);
                  if (bit_cnt == LAST_BIT) begin
                     last_q <= 1'b1;
                  end
               end
            end
            RETIRE: begin
               state <= IDLE;
            end
            default: begin
               state <= IDLE;
            end
         endcase
      end
   end

   assign o_ready   = (state == IDLE);
   assign o_accept  = o_ready & i_instr_valid;
   assign o_cnt_en  = (state == RUN) & ~last_q;
   assign o_first   = o_cnt_en & (bit_cnt == '0);
   assign o_last    = last_q;
   assign o_bit_cnt = bit_cnt;
   assign o_retire  = (state == RETIRE);

endmodule

/* verilog/serial_core_top.sv */
module serial_core_top #(
   parameter int XLEN = isa_pkg::XLEN
) (
   input  logic               clk,
   input  logic               i_rst,
   input  logic               i_instr_valid,
   input  isa_pkg::instr_t    i_instr,
   output logic               o_ready,
   output logic               o_retire,
   output isa_pkg::reg_addr_t o_retire_rd,
   output isa_pkg::word_t     o_retire_data,
   output logic               o_retire_we,
   output logic               o_illegal
);
   import isa_pkg::*;
   import core_pkg::*;

   logic      accept;
   logic      cnt_en;
   logic      first;
   logic      last;
   logic      retire;
   logic      rs1_bit;
   logic      rs2_bit;
   logic      rd_en;
   logic      illegal;
   bit_cnt_t  bit_cnt;
   reg_addr_t rs1_addr;
   reg_addr_t rs2_addr;
   reg_addr_t rd_addr;
   word_t     result;

   alu_ctrl_if alu_ctrl ();

   exec_sequencer #(
      .XLEN(XLEN)
   ) u_seq (
      .clk           (clk),
      .i_rst         (i_rst),
      .i_instr_valid (i_instr_valid),
      .o_accept      (accept),
      .o_cnt_en      (cnt_en),
      .o_first       (first),
      .o_last        (last),
      .o_bit_cnt     (bit_cnt),
      .o_retire      (retire),
      .o_ready       (o_ready)
   );

   serial_decode u_dec (
      .clk           (clk),
      .i_rst         (i_rst),
      .i_instr_valid (i_instr_valid),
      .i_accept      (accept),
      .i_instr       (i_instr),
      .i_cnt_en      (cnt_en),
      .o_rs1_addr    (rs1_addr),
      .o_rs2_addr    (rs2_addr),
      .o_rd_addr     (rd_addr),
      .o_rd_en       (rd_en),
      .o_illegal     (illegal),
      .ctrl          (alu_ctrl.dec)
   );

   serial_alu #(
      .XLEN(XLEN)
   ) u_alu (
      .clk       (clk),
      .i_rst     (i_rst),
      .i_cnt_en  (cnt_en),
      .i_first   (first),
      .i_bit_cnt (bit_cnt),
      .i_rs1_bit (rs1_bit),
      .i_rs2_bit (rs2_bit),
      .ctrl      (alu_ctrl.alu),
      .o_result  (result)
   );

   // Write lands on the edge that starts the retire cycle
   serial_regfile #(
      .XLEN(XLEN)
   ) u_rf (
      .clk        (clk),
      .i_rst      (i_rst),
      .i_bit_cnt  (bit_cnt),
      .i_rs1_addr (rs1_addr),
      .i_rs2_addr (rs2_addr),
      .i_wr_en    (rd_en & last),
      .i_rd_addr  (rd_addr),
      .i_wr_data  (result),
      .o_rs1_bit  (rs1_bit),
      .o_rs2_bit  (rs2_bit)
   );

   assign o_retire      = retire;
   assign o_retire_rd   = rd_addr;
   assign o_retire_data = result;
   assign o_retire_we   = rd_en & retire;
   assign o_illegal     = illegal & retire;

endmodule

/* bench/core_model.svh */
`ifndef CORE_MODEL_SVH
`define CORE_MODEL_SVH

// Reference copy of the architectural registers
word_t ref_regs [32];

// I-type immediate sign-extended from bit 31
function automatic word_t imm_i(input instr_t ins);
   return {{20{ins[31]}}, ins[31:20]};
endfunction

// Expected outcome of one instruction and the reference write
function automatic void predict(input instr_t ins, output word_t data,
                                output logic we, output logic ill);
   opcode_t   opc;
   funct3_t   f3;
   reg_addr_t rd;
   word_t     a;
   word_t     b;
   logic      arith;
   opc   = ins[6:2];
   f3    = ins[14:12];
   rd    = ins[11:7];
   a     = ref_regs[ins[19:15]];
   b     = (opc == OPC_OP) ? ref_regs[ins[24:20]] : imm_i(ins);
   arith = (opc == OPC_OP) || (opc == OPC_OP_IMM);
   ill   = (ins[1:0] != 2'b11) || !(arith || (opc == OPC_LUI)) ||
           (arith && ((f3 == F3_SLL) || (f3 == F3_SR)));
   data  = '0;
   if (!ill && (opc == OPC_LUI)) begin
      data = {ins[31:12], 12'b0};
   end else if (!ill) begin
      case (f3)
         // Only register-register ADD has the SUB variant
         F3_ADD:  data = ((opc == OPC_OP) && ins[30]) ? a - b : a + b;
         F3_SLT:  data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         F3_SLTU: data = (a < b) ? 32'd1 : 32'd0;
         F3_XOR:  data = a ^ b;
         F3_OR:   data = a | b;
         F3_AND:  data = a & b;
         default: data = '0;
      endcase
   end
   we = !ill && (rd != '0);
   if (we) begin
      ref_regs[rd] = data;
   end
endfunction

`endif

/* bench/tb_serial_core.sv */
module tb_serial_core;
   timeunit 1ns;
   timeprecision 100ps;
   import isa_pkg::*;

   `include "core_model.svh"

   localparam int READY_LIMIT  = 100;
   localparam int RETIRE_LIMIT = 100;

   logic      clk;
   logic      i_rst;
   logic      i_instr_valid;
   instr_t    i_instr;
   logic      o_ready;
   logic      o_retire;
   reg_addr_t o_retire_rd;
   word_t     o_retire_data;
   logic      o_retire_we;
   logic      o_illegal;
   logic [15:0] lfsr_q = 16'd33;

   serial_core_top #(
      .XLEN(32)
   ) dut0 (
      .clk           (clk),
      .i_rst         (i_rst),
      .i_instr_valid (i_instr_valid),
      .i_instr       (i_instr),
      .o_ready       (o_ready),
      .o_retire      (o_retire),
      .o_retire_rd   (o_retire_rd),
      .o_retire_data (o_retire_data),
      .o_retire_we   (o_retire_we),
      .o_illegal     (o_illegal)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // Taps 16, 14, 13, 11
   function automatic logic lfsr_step();
      logic fb;
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      return fb;
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r = {r[30:0], lfsr_step()};
      end
      return r;
   endfunction

   function automatic instr_t enc_op(input funct3_t f3, input logic alt, input reg_addr_t rd,
                                     input reg_addr_t rs1, input reg_addr_t rs2);
      return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OPC_OP, 2'b11};
   endfunction

   function automatic instr_t enc_imm(input funct3_t f3, input reg_addr_t rd,
                                      input reg_addr_t rs1, input logic [11:0] imm);
      return {imm, rs1, f3, rd, OPC_OP_IMM, 2'b11};
   endfunction

   function automatic instr_t enc_lui(input reg_addr_t rd, input logic [19:0] imm);
      return {imm, rd, OPC_LUI, 2'b11};
   endfunction

   task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
      if (got !== exp) begin
         $display("Mismatch at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
         $display("*** TEST FAILED ***");
         $fatal(1, "stopping at first error");
      end
   endtask

   task automatic report_timeout(input string what);
      $display("Timeout at %0t ns: %s", $time, what);
      $display("*** TEST FAILED ***");
      $fatal(1, "stopping on timeout");
   endtask

   task automatic wait_ready();
      int n;
      n = 0;
      while (!o_ready) begin
         if (n >= READY_LIMIT) begin
            report_timeout("o_ready never rose");
         end else begin
            @(posedge clk);
            n++;
         end
      end
   endtask

   // Issue one instruction and optionally hold the strobe while busy
   task automatic run_instr(input instr_t ins, input logic hold_valid);
      word_t exp_data;
      logic  exp_we;
      logic  exp_ill;
      logic  done;
      int    n;
      wait_ready();
      i_instr_valid <= 1'b1;
      i_instr       <= ins;
      @(posedge clk);
      check_equal(32'(o_ready), 32'd1, "o_ready at accept edge");
      i_instr_valid <= hold_valid;
      predict(ins, exp_data, exp_we, exp_ill);
      n    = 0;
      done = 1'b0;
      while (!done) begin
         if (n >= RETIRE_LIMIT) begin
            report_timeout("no o_retire after accept");
         end else begin
            @(posedge clk);
            n++;
            if (n == 8) begin
               i_instr_valid <= 1'b0;
            end
            done = o_retire;
         end
      end
      check_equal(32'(n), 32'd34, "retire latency in cycles");
      check_equal(32'(o_retire_rd), 32'(ins[11:7]), "o_retire_rd");
      check_equal(32'(o_illegal), 32'(exp_ill), "o_illegal");
      check_equal(32'(o_retire_we), 32'(exp_we), "o_retire_we");
      if (!exp_ill) begin
         check_equal(o_retire_data, exp_data, "o_retire_data");
      end
   endtask

   initial begin
      funct3_t   f3;
      logic      is_reg;
      instr_t    ins;
      i_rst         <= 1'b1;
      i_instr_valid <= 1'b0;
      i_instr       <= '0;
      for (int r = 0; r < 32; r++) begin
         ref_regs[r] = '0;
      end
      repeat (16) @(posedge clk);
      i_rst <= 1'b0;
      @(posedge clk);
      check_equal(32'(o_ready), 32'd1, "o_ready after reset");
      check_equal(32'(o_retire), 32'd0, "o_retire after reset");

      // LUI fills the registers with known values
      for (int k = 0; k < 12; k++) begin
         run_instr(enc_lui(reg_addr_t'(rand_bits(5)), 20'(rand_bits(20))), 1'b0);
      end

      // Random register and immediate arithmetic with shifts remapped to ADD
      for (int k = 0; k < 60; k++) begin
         is_reg = lfsr_step();
         f3     = funct3_t'(rand_bits(3));
         if ((f3 == F3_SLL) || (f3 == F3_SR)) begin
            f3 = F3_ADD;
         end
         if (is_reg) begin
            ins = enc_op(f3, (f3 == F3_ADD) & lfsr_step(), reg_addr_t'(rand_bits(5)),
                         reg_addr_t'(rand_bits(5)), reg_addr_t'(rand_bits(5)));
         end else begin
            ins = enc_imm(f3, reg_addr_t'(rand_bits(5)), reg_addr_t'(rand_bits(5)),
                          12'(rand_bits(12)));
         end
         run_instr(ins, 1'b0);
      end

      // Compares with opposite signs and equal values
      run_instr(enc_lui(5'd1, 20'h80000), 1'b0);
      run_instr(enc_lui(5'd2, 20'h7ffff), 1'b0);
      run_instr(enc_op(F3_SLT, 1'b0, 5'd3, 5'd1, 5'd2), 1'b0);
      run_instr(enc_op(F3_SLTU, 1'b0, 5'd3, 5'd1, 5'd2), 1'b0);
      run_instr(enc_op(F3_SLT, 1'b0, 5'd3, 5'd2, 5'd2), 1'b0);
      run_instr(enc_op(F3_SLTU, 1'b0, 5'd3, 5'd1, 5'd1), 1'b0);
      run_instr(enc_imm(F3_SLT, 5'd4, 5'd1, 12'hfff), 1'b0);
      run_instr(enc_imm(F3_SLTU, 5'd4, 5'd2, 12'hfff), 1'b0);
      run_instr(enc_imm(F3_SLT, 5'd4, 5'd2, 12'h800), 1'b0);

      // Writes to x0 are dropped and x0 reads back as zero
      run_instr(enc_imm(F3_ADD, 5'd0, 5'd2, 12'h123), 1'b0);
      run_instr(enc_imm(F3_ADD, 5'd7, 5'd0, 12'h123), 1'b0);
      run_instr(enc_op(F3_OR, 1'b0, 5'd8, 5'd0, 5'd0), 1'b0);

      // Shifts and unknown opcodes with the strobe held high while busy
      run_instr(enc_op(F3_SLL, 1'b0, 5'd9, 5'd1, 5'd2), 1'b1);
      repeat (40) begin
         @(posedge clk);
         check_equal(32'(o_retire), 32'd0, "o_retire after ignored strobe");
      end
      run_instr(enc_imm(F3_SR, 5'd9, 5'd2, 12'h401), 1'b0);
      run_instr({25'(rand_bits(25)), 5'b00000, 2'b11}, 1'b0);
      run_instr({25'(rand_bits(25)), 5'b11000, 2'b11}, 1'b0);
      run_instr({25'(rand_bits(25)), 5'b00101, 2'b11}, 1'b0);
      run_instr(enc_op(F3_ADD, 1'b0, 5'd10, 5'd9, 5'd0), 1'b0);

      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule

/* all.f */
+incdir+bench
verilog/isa_pkg.sv
verilog/core_pkg.sv
verilog/alu_ctrl_if.sv
verilog/serial_decode.sv
verilog/serial_alu.sv
verilog/serial_regfile.sv
verilog/exec_sequencer.sv
verilog/serial_core_top.sv
bench/tb_serial_core.sv

/* Makefile */
TOP = tb_serial_core
LOG = sim.log

all: run

obj_dir/V$(TOP): all.f verilog/*.sv bench/*.sv bench/*.svh
	verilator --binary -f all.f --top-module $(TOP) -j 0

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "\*\*\* TEST PASSED \*\*\*" $(LOG)

lint:
	verilator --lint-only -Wall -f all.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all run lint clean
